// File: tb.f
+incdir+hdl
hdl/ifu_pkg.sv
hdl/ifu_addr_gen.sv
hdl/itlb_entry.sv
hdl/itlb_select.sv
hdl/ifu_controller.sv
hdl/ifu_top.sv
bench/tb_ifu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_ifu
FILELIST  := tb.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) hdl/ifu_cfg.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// File: bench/tb_ifu.sv
`default_nettype none

`include "ifu_cfg.svh"

module tb_ifu;

   localparam int CLK_PERIOD = 40;
   localparam int MAX_CYCLES = 10 + 2 * `ITLB_ENTRIES + 40 * 12;
   localparam logic [3:0] FL_V  = 4'd1 << `PTE_V;
   localparam logic [3:0] FL_VP = FL_V | (4'd1 << `PTE_P);

   logic                 clk;
   logic                 arst_n;
   logic                 v_mem_rd;
   logic [31:0]          va_rd_addr;
   logic [15:0]          cseg;
   ifu_pkg::tlb_wr_t     tlb_wr;
   logic [127:0]         icache_rd_data;
   logic                 icache_ready;
   ifu_pkg::icache_req_t icache_req;
   logic                 rd_stall;
   logic                 page_fault;
   logic [127:0]         rd_data;

   // reference copy of what was loaded into the itlb
   logic [19:0] tlb_vpn [`ITLB_ENTRIES];
   logic [19:0] tlb_ppn [`ITLB_ENTRIES];
   logic [3:0]  tlb_flags [`ITLB_ENTRIES];
   logic [15:0] lfsr;
   int          cycle_cnt = 0;

   ifu_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: the fetch sequence did not finish within %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string tname, input string what,
                              input logic [127:0] actual, input logic [127:0] expected);
      assert (actual === expected) else begin
         $display("Fail %s %s: expected %0h actual %0h", tname, what, expected, actual);
         $display("*** TEST FAILED ***");
         $fatal(1, "check failed");
      end
   endtask

   task automatic check_idle(input string tname);
      check_value(tname, "icache_req.en", 128'(icache_req.en), 128'(1'b0));
      check_value(tname, "rd_stall", 128'(rd_stall), 128'(1'b0));
      check_value(tname, "page_fault", 128'(page_fault), 128'(1'b0));
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v = {v[30:0], lfsr[0]};
      end
   endtask

   // cache contents as a function of the physical byte address
   function automatic logic [7:0] mem_byte(input logic [31:0] p);
      return p[7:0] ^ p[15:8];
   endfunction

   function automatic logic [127:0] cache_line(input logic [31:0] a, input logic [4:0] sz);
      logic [127:0] line;
      line = '0;
      for (int k = 0; k < int'(sz); k++) begin
         line[8*k +: 8] = mem_byte(a + 32'(k));
      end
      return line;
   endfunction

   // returns {present, ppn} of a valid matching entry
   function automatic logic [20:0] lookup_page(input logic [19:0] vpn);
      logic [20:0] res;
      res = '0;
      for (int i = 0; i < `ITLB_ENTRIES; i++) begin
         if (tlb_flags[i][`PTE_V] && tlb_vpn[i] == vpn) begin
            res = {tlb_flags[i][`PTE_P], tlb_ppn[i]};
         end
      end
      return res;
   endfunction

   task automatic load_entry(input int idx, input logic [19:0] vpn, input logic [19:0] ppn,
                             input logic [3:0] flags);
      @(posedge clk);
      #2;
      tlb_wr.we      = 1'b1;
      tlb_wr.idx     = ifu_pkg::ITLB_IDX_W'(idx);
      tlb_wr.vpn     = vpn;
      tlb_wr.ppn     = ppn;
      tlb_wr.flags   = flags;
      tlb_vpn[idx]   = vpn;
      tlb_ppn[idx]   = ppn;
      tlb_flags[idx] = flags;
      @(posedge clk);
      #2;
      tlb_wr = '0;
   endtask

   task automatic run_fetch(input string tname, input logic [31:0] va, input logic [15:0] cs);
      logic [31:0]          la;
      logic [3:0]           off;
      logic                 cross_pg;
      logic [20:0]          pg1;
      logic [20:0]          pg2;
      logic                 fault;
      logic [31:0]          addr [2];
      logic [4:0]           size [2];
      logic [127:0]         exp_data;
      logic [31:0]          delay;
      int                   n_acc;
      ifu_pkg::icache_req_t exp_req;
      la       = va + {cs, 16'h0000};
      off      = la[3:0];
      cross_pg = (off != 4'h0) && (la[11:4] == 8'hff);
      pg1      = lookup_page(la[31:12]);
      pg2      = lookup_page(la[31:12] + 20'd1);
      fault    = !pg1[20] || (cross_pg && !pg2[20]);
      n_acc    = (off != 4'h0) ? 2 : 1;
      addr[0]  = {pg1[19:0], la[11:0]};
      addr[1]  = cross_pg ? {pg2[19:0], 12'h000} : (addr[0] | 32'hf) + 32'd1;
      size[0]  = 5'd16 - {1'b0, off};
      size[1]  = {1'b0, off};
      // sixteen consecutive bytes with the first one in the top lane
      for (int k = 0; k < 16; k++) begin
         if (k < int'(size[0])) begin
            exp_data[127 - 8*k -: 8] = mem_byte(addr[0] + 32'(k));
         end else begin
            exp_data[127 - 8*k -: 8] = mem_byte(addr[1] + 32'(k) - 32'(size[0]));
         end
      end
      @(posedge clk);
      #2;
      v_mem_rd     = 1'b1;
      va_rd_addr   = va;
      cseg         = cs;
      icache_ready = 1'b0;
      if (fault) begin
         @(negedge clk);
         check_value(tname, "page_fault", 128'(page_fault), 128'(1'b1));
         check_value(tname, "icache_req.en", 128'(icache_req.en), 128'(1'b0));
         check_value(tname, "rd_stall", 128'(rd_stall), 128'(1'b0));
         @(posedge clk);
         #2;
      end else begin
         for (int j = 0; j < n_acc; j++) begin
            exp_req.addr = addr[j];
            exp_req.size = size[j];
            exp_req.en   = 1'b1;
            rand_bits(2, delay);
            // request must hold while the cache stalls
            for (int d = 0; d < int'(delay); d++) begin
               @(negedge clk);
               check_value(tname, "icache_req", 128'(icache_req), 128'(exp_req));
               check_value(tname, "rd_stall", 128'(rd_stall), 128'(1'b1));
               @(posedge clk);
               #2;
            end
            icache_ready   = 1'b1;
            icache_rd_data = cache_line(addr[j], size[j]);
            @(negedge clk);
            check_value(tname, "icache_req", 128'(icache_req), 128'(exp_req));
            check_value(tname, "page_fault", 128'(page_fault), 128'(1'b0));
            check_value(tname, "rd_stall", 128'(rd_stall), 128'(j != n_acc - 1));
            if (j == n_acc - 1) begin
               check_value(tname, "rd_data", rd_data, exp_data);
            end
            @(posedge clk);
            #2;
            icache_ready   = 1'b0;
            icache_rd_data = '0;
         end
      end
      v_mem_rd = 1'b0;
   endtask

   initial begin
      logic [31:0] r;
      arst_n         = 1'b0;
      v_mem_rd       = 1'b0;
      va_rd_addr     = '0;
      cseg           = '0;
      tlb_wr         = '0;
      icache_rd_data = '0;
      icache_ready   = 1'b0;
      lfsr           = 16'd55;
      for (int i = 0; i < `ITLB_ENTRIES; i++) begin
         tlb_vpn[i]   = '0;
         tlb_ppn[i]   = '0;
         tlb_flags[i] = '0;
      end
      repeat (10) @(posedge clk);
      #2;
      arst_n = 1'b1;
      @(negedge clk);
      check_idle("reset");
      // pages 0x10 and 0x11 map to non-adjacent frames and 0x21 is not present
      load_entry(0, 20'h00010, 20'h00123, FL_VP);
      load_entry(1, 20'h00011, 20'h00abc, FL_VP);
      load_entry(2, 20'h00020, 20'h00456, FL_VP);
      load_entry(3, 20'h00021, 20'h00777, FL_V);
      load_entry(4, 20'h00030, 20'h00088, FL_VP);
      run_fetch("aligned", 32'h0000_0100, 16'h0001);
      run_fetch("aligned no segment", 32'h0003_0040, 16'h0000);
      run_fetch("aligned last line", 32'h0000_0ff0, 16'h0001);
      for (int i = 0; i < 5; i++) begin
         rand_bits(8, r);
         run_fetch("aligned", {20'h00020, r[7:0], 4'h0} - 32'h0001_0000, 16'h0001);
      end
      run_fetch("unaligned segment", 32'h0001_0208, 16'h0002);
      for (int i = 0; i < 10; i++) begin
         rand_bits(12, r);
         if (r[3:0] == 4'h0) begin
            r[3:0] = 4'h8;
         end
         if (r[11:4] == 8'hff) begin
            r[11:4] = 8'h00;
         end
         run_fetch("unaligned", {(i[0] ? 20'h00010 : 20'h00020), r[11:0]} - 32'h0001_0000,
                   16'h0001);
      end
      for (int i = 0; i < 6; i++) begin
         rand_bits(4, r);
         if (r[3:0] == 4'h0) begin
            r[3:0] = 4'h1;
         end
         run_fetch("page cross", {20'h00010, 8'hff, r[3:0]} - 32'h0001_0000, 16'h0001);
      end
      run_fetch("unmapped", 32'h0003_0004, 16'h0001);
      run_fetch("next not present", 32'h0001_0ff4, 16'h0001);
      run_fetch("not present", 32'h0001_1000, 16'h0001);
      run_fetch("after fault", 32'h0000_0ffc, 16'h0001);
      @(negedge clk);
      check_idle("final");
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/ifu_top.sv
`default_nettype none

`include "ifu_cfg.svh"

module ifu_top (
   input  logic                 clk,
   input  logic                 arst_n,

   // fetch stage
   input  logic                 v_mem_rd,
   input  logic [31:0]          va_rd_addr,
   input  logic [15:0]          cseg,

   // tlb loader
   input  ifu_pkg::tlb_wr_t     tlb_wr,

   // instruction cache
   input  logic [127:0]         icache_rd_data,
   input  logic                 icache_ready,
   output ifu_pkg::icache_req_t icache_req,

   output logic                 rd_stall,
   output logic                 page_fault,
   output logic [127:0]         rd_data
);

   ifu_pkg::fetch_addr_t     fa;
   ifu_pkg::xlate_t          xl;
   logic [`ITLB_ENTRIES-1:0] hit1;
   logic [`ITLB_ENTRIES-1:0] hit2;
   ifu_pkg::itlb_pte_t       pte [`ITLB_ENTRIES];

   ifu_addr_gen u_addr_gen (
      .va_rd_addr (va_rd_addr),
      .cseg       (cseg),
      .fa         (fa)
   );

   // one entry per slot, all searched in parallel
   for (genvar i = 0; i < `ITLB_ENTRIES; i++) begin : g_entry
      itlb_entry #(
         .ENTRY_ID (i)
      ) u_entry (
         .clk    (clk),
         .arst_n (arst_n),
         .tlb_wr (tlb_wr),
         .fa     (fa),
         .hit1   (hit1[i]),
         .hit2   (hit2[i]),
         .pte    (pte[i])
      );
   end

   itlb_select u_select (
      .hit1       (hit1),
      .hit2       (hit2),
      .pte        (pte),
      .fa         (fa),
      .v_mem_rd   (v_mem_rd),
      .xl         (xl),
      .page_fault (page_fault)
   );

   ifu_controller u_ctrl (
      .clk            (clk),
      .arst_n         (arst_n),
      .v_mem_rd       (v_mem_rd),
      .fa             (fa),
      .xl             (xl),
      .icache_rd_data (icache_rd_data),
      .icache_ready   (icache_ready),
      .icache_req     (icache_req),
      .rd_stall       (rd_stall),
      .rd_data        (rd_data)
   );

endmodule

`default_nettype wire

// File: hdl/ifu_controller.sv
`default_nettype none

module ifu_controller (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  v_mem_rd,
   input  ifu_pkg::fetch_addr_t  fa,
   input  ifu_pkg::xlate_t       xl,
   input  logic [127:0]          icache_rd_data,
   input  logic                  icache_ready,
   output ifu_pkg::icache_req_t  icache_req,
   output logic                  rd_stall,
   output logic [127:0]          rd_data
);

   ifu_pkg::fetch_state_e state;
   ifu_pkg::fetch_state_e state_nxt;

   logic [31:0]  addr1;
   logic [31:0]  addr2;
   logic         en;
   logic         in_second;
   logic         done;
   logic         first_cap;
   logic [127:0] first_half;
   logic [7:0]   shamt;
   logic [127:0] low_mask;
   logic [127:0] merged;

   assign in_second = (state == ifu_pkg::st_second);

   assign addr1 = {xl.ppn1, fa.la[11:0]};

   // next line, either in this page or at the start of the next one
   assign addr2 = fa.cross_pg ? {xl.ppn2, 12'h000}
                              : {xl.ppn1, fa.la[11:4] + 8'd1, 4'h0};

   assign en = v_mem_rd & ~xl.fault;

   assign done = icache_ready & (in_second | ~fa.cross_cl);

   assign rd_stall = en & ~done;

   // first half of a split fetch lands this cycle
   assign first_cap = en & ~in_second & fa.cross_cl & icache_ready;

   always_comb begin
      icache_req.en   = en;
      icache_req.addr = in_second ? addr2 : addr1;
      icache_req.size = in_second ? fa.size2 : fa.size1;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ifu_pkg::st_first: begin
            if (first_cap) begin
               state_nxt = ifu_pkg::st_second;
            end
         end
         ifu_pkg::st_second: begin
            // drop back if the request went away or finished
            if (!en || icache_ready) begin
               state_nxt = ifu_pkg::st_first;
            end
         end
         default: begin
            state_nxt = ifu_pkg::st_first;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= ifu_pkg::st_first;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (first_cap) begin
         first_half <= icache_rd_data;
      end
   end

   // size1 lanes from the buffer, second access above them
   assign shamt    = {fa.size1, 3'b000};
   assign low_mask = ~({128{1'b1}} << shamt);

   always_comb begin
      if (in_second) begin
         merged = (first_half & low_mask) | (icache_rd_data << shamt);
      end else begin
         merged = icache_rd_data;
      end
   end

   // fetch order puts lane 0 on top
   always_comb begin
      for (int i = 0; i < 16; i++) begin
         rd_data[127 - 8*i -: 8] = merged[8*i +: 8];
      end
   end

endmodule

`default_nettype wire

// File: hdl/itlb_select.sv
`default_nettype none

`include "ifu_cfg.svh"

module itlb_select (
   input  logic [`ITLB_ENTRIES-1:0] hit1,
   input  logic [`ITLB_ENTRIES-1:0] hit2,
   input  ifu_pkg::itlb_pte_t       pte [`ITLB_ENTRIES],
   input  ifu_pkg::fetch_addr_t     fa,
   input  logic                     v_mem_rd,
   output ifu_pkg::xlate_t          xl,
   output logic                     page_fault
);

   localparam int PTE_W = $bits(ifu_pkg::itlb_pte_t);

   ifu_pkg::itlb_pte_t sel1;
   ifu_pkg::itlb_pte_t sel2;
   logic               v1;
   logic               v2;

   // and-or mux over the one-hot hits
   always_comb begin
      sel1 = '0;
      sel2 = '0;
      for (int i = 0; i < `ITLB_ENTRIES; i++) begin
         sel1 = sel1 | (pte[i] & {PTE_W{hit1[i]}});
         sel2 = sel2 | (pte[i] & {PTE_W{hit2[i]}});
      end
   end

   // hit already implies V, present is checked here
   assign v1 = (|hit1) & sel1.flags[`PTE_P];
   assign v2 = (|hit2) & sel2.flags[`PTE_P];

   // next page only matters when the fetch leaves this page
   assign page_fault = v_mem_rd & (~v1 | (fa.cross_pg & ~v2));

   always_comb begin
      xl.ppn1  = sel1.ppn;
      xl.ppn2  = sel2.ppn;
      xl.v1    = v1;
      xl.v2    = v2;
      xl.fault = page_fault;
   end

endmodule

`default_nettype wire

// File: hdl/itlb_entry.sv
`default_nettype none

`include "ifu_cfg.svh"

module itlb_entry #(
   parameter int ENTRY_ID = 0
) (
   input  logic                clk,
   input  logic                arst_n,
   input  ifu_pkg::tlb_wr_t    tlb_wr,
   input  ifu_pkg::fetch_addr_t fa,
   output logic                hit1,
   output logic                hit2,
   output ifu_pkg::itlb_pte_t  pte
);

   localparam logic [ifu_pkg::ITLB_IDX_W-1:0] MY_IDX = ifu_pkg::ITLB_IDX_W'(ENTRY_ID);

   logic [19:0] vpn;
   logic        wr_sel;

   assign wr_sel = tlb_wr.we && (tlb_wr.idx == MY_IDX);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vpn <= '0;
         pte <= '0;
      end else if (wr_sel) begin
         vpn       <= tlb_wr.vpn;
         pte.ppn   <= tlb_wr.ppn;
         pte.flags <= tlb_wr.flags;
      end
   end

   // tag compare for both pages of the fetch
   assign hit1 = pte.flags[`PTE_V] && (vpn == fa.la[31:12]);
   assign hit2 = pte.flags[`PTE_V] && (vpn == fa.vpn2);

endmodule

`default_nettype wire

// File: hdl/ifu_addr_gen.sv
`default_nettype none

module ifu_addr_gen (
   input  logic [31:0]          va_rd_addr,
   input  logic [15:0]          cseg,
   output ifu_pkg::fetch_addr_t fa
);

   logic [31:0] la;
   logic [3:0]  offset;
   logic        cross_cl;
   logic        cross_pg;

   // code segment base sits in the upper half
   assign la = va_rd_addr + {cseg, 16'h0000};

   assign offset = la[3:0];

   // any nonzero offset spills into the next 16-byte line
   assign cross_cl = |offset;

   // last line of the 4k page
   assign cross_pg = cross_cl & (&la[11:4]);

   always_comb begin
      fa.la       = la;
      fa.cross_cl = cross_cl;
      fa.cross_pg = cross_pg;

      // first access runs to the end of the line
      fa.size1 = 5'd16 - {1'b0, offset};

      // the remainder comes from the following line
      fa.size2 = {1'b0, offset};

      // page number looked up for the second access
      fa.vpn2 = la[31:12] + 20'd1;
   end

endmodule

`default_nettype wire

// File: hdl/ifu_pkg.sv
`default_nettype none

`include "ifu_cfg.svh"

package ifu_pkg;

   localparam int ITLB_IDX_W = $clog2(`ITLB_ENTRIES);

   // two-access fetch sequencing
   typedef enum logic {
      st_first,
      st_second
   } fetch_state_e;

   // loader write port into the itlb
   typedef struct packed {
      logic                  we;
      logic [ITLB_IDX_W-1:0] idx;
      logic [19:0]           vpn;
      logic [19:0]           ppn;
      logic [3:0]            flags;
   } tlb_wr_t;

   typedef struct packed {
      logic [31:0] la;
      logic [19:0] vpn2;
      logic        cross_cl;
      logic        cross_pg;
      logic [4:0]  size1;
      logic [4:0]  size2;
   } fetch_addr_t;

   typedef struct packed {
      logic [19:0] ppn;
      logic [3:0]  flags;
   } itlb_pte_t;

   typedef struct packed {
      logic [19:0] ppn1;
      logic [19:0] ppn2;
      logic        v1;
      logic        v2;
      logic        fault;
   } xlate_t;

   typedef struct packed {
      logic [31:0] addr;
      logic [4:0]  size;
      logic        en;
   } icache_req_t;

endpackage

`default_nettype wire

// File: hdl/ifu_cfg.svh
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// itlb size
// fully associative, any count of 2 or more
`define ITLB_ENTRIES 8

// flag bit positions in the 4-bit entry flags field
`define PTE_V 0
`define PTE_P 1

`endif
